// File: vlog.f
common/fight_pkg.sv
rtl/match_ctrl.sv
player/player_fsm.sv
rtl/hit_detect.sv
rtl/health_status.sv
rtl/cpu_input.sv
rtl/fight_core.sv
sim/tb_fight_core.sv

// File: sim/tb_fight_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fight_core
  import fight_pkg::*;
();

  localparam int FRAME_DIV   = 4;
  localparam int STEP        = 4;
  localparam int STUN_FRAMES = 8;
  localparam int CPU_TICKS   = 40;

  logic            clk;
  logic            arst_n;
  logic            start;
  logic            p1_left, p1_right, p1_attack;
  logic            p2_left, p2_right, p2_attack;
  logic            cpu_mode;
  logic            frame_tick;
  match_state_t    match_state;
  logic [X_W-1:0]  p1_x, p2_x;
  player_state_t   p1_state, p2_state;
  logic [HP_W-1:0] p1_health, p2_health, p1_block, p2_block;

  int              i;
  int              moves;                      // p2_x changes seen under CPU control
  logic [X_W-1:0]  exp_x;
  logic [X_W-1:0]  frozen_p1, frozen_p2;
  logic [HP_W-1:0] exp_health, exp_block;      // Model of p2 counters
  logic [31:0]     rng_state;
  logic [X_W-1:0]  trace [2][CPU_TICKS];       // p2_x per tick with one row per CPU run
  logic [X_W-1:0]  last_p2_x;
  logic [X_W-1:0]  delta;
  logic            last_tick;

  fight_core #(.FRAME_DIV(FRAME_DIV)) i_fight_core (
    .clk(clk), .arst_n(arst_n), .start(start),
    .p1_left(p1_left), .p1_right(p1_right), .p1_attack(p1_attack),
    .p2_left(p2_left), .p2_right(p2_right), .p2_attack(p2_attack),
    .cpu_mode(cpu_mode), .frame_tick(frame_tick), .match_state(match_state),
    .p1_x(p1_x), .p2_x(p2_x), .p1_state(p1_state), .p2_state(p2_state),
    .p1_health(p1_health), .p2_health(p2_health),
    .p1_block(p1_block), .p2_block(p2_block)
  );

  always #10 clk = ~clk;  // 20 ns period

  //============================================================
  // Helpers
  //============================================================

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else
      fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
  endtask

  // Returns just after the next tick edge
  task automatic next_frame();
    int n;
    n = 0;
    while (!frame_tick) begin
      @(posedge clk);
      #2;
      n++;
      if (n > 4 * FRAME_DIV) fail_now("frame_tick did not arrive in time");
    end
    @(posedge clk);  // The tick edge itself
    #2;
  endtask

  task automatic apply_reset();
    cpu_mode  = 1'b0;
    start     = 1'b0;
    {p1_left, p1_right, p1_attack} = 3'b000;
    {p2_left, p2_right, p2_attack} = 3'b000;
    arst_n    = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    arst_n    = 1'b1;
  endtask

  task automatic start_round();
    start = 1'b1;
    next_frame();
    check_eq("match_state", match_state, M_FIGHT);
    start = 1'b0;
    @(posedge clk);  // Players and counters reload one clk later
    #2;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (p1_state != P_IDLE || p2_state != P_IDLE) begin
      next_frame();
      n++;
      if (n > 20) fail_now("players did not return to idle");
    end
  endtask

  // Walk p2 forward until the bodies touch
  task automatic close_gap();
    int n;
    n = 0;
    p2_left = 1'b1;
    while (p2_x != p1_x + BODY_W) begin
      next_frame();
      n++;
      if (n > 100) fail_now("p2 did not reach contact with p1");
    end
    p2_left = 1'b0;
    next_frame();
  endtask

  // One p1 attack on p2 with an optional p2 guard
  task automatic strike_p2(input logic guard);
    logic stunned;
    stunned   = 1'b0;
    p1_attack = 1'b1;
    next_frame();
    check_eq("p1_state", p1_state, P_ATTACK);
    p1_attack = 1'b0;
    p2_right  = guard;    // Back key seen on the hit tick
    next_frame();
    p2_right  = 1'b0;
    @(posedge clk);       // Counters move 1 clk after the tick
    #2;
    @(posedge clk);       // Stun shows 2 clk after the tick
    #2;
    if (guard && exp_block != '0) begin
      exp_block = exp_block - 1'b1;
    end else begin
      if (exp_health != '0) exp_health = exp_health - 1'b1;
      stunned = 1'b1;
    end
    check_eq("p2_health", p2_health, exp_health);
    check_eq("p2_block", p2_block, exp_block);
    if (stunned) begin
      check_eq("p2_state", p2_state, P_HITSTUN);
    end else begin
      assert (p2_state != P_HITSTUN) else fail_now("blocked hit put p2 in hit-stun");
    end
  endtask

  // Fresh reset then random p2 keys under CPU control
  task automatic cpu_run(input int run);
    int k;
    apply_reset();
    start_round();
    cpu_mode = 1'b1;
    for (k = 0; k < CPU_TICKS; k++) begin
      rng_state = xorshift(rng_state);
      {p2_attack, p2_right, p2_left} = rng_state[2:0];
      next_frame();
      trace[run][k] = p2_x;
      if (k > 0 && trace[run][k] != trace[run][k-1]) moves++;
    end
    {p2_left, p2_right, p2_attack} = 3'b000;
    cpu_mode = 1'b0;
  endtask

  //============================================================
  // Running checks on every clock
  //============================================================

  always @(negedge clk) begin
    if (arst_n) begin
      assert (p1_x + BODY_W <= p2_x) else fail_now("player bodies overlap");
      assert (p1_x <= ARENA_MAX && p2_x <= ARENA_MAX) else fail_now("player left the arena");
      if (cpu_mode && p2_x != last_p2_x) begin
        assert (last_tick) else fail_now("p2_x changed away from a frame tick");
        delta = (p2_x > last_p2_x) ? p2_x - last_p2_x : last_p2_x - p2_x;
        check_eq("p2_x step", delta, STEP);
      end
    end
    last_p2_x <= p2_x;
    last_tick <= frame_tick;  // Tick is high in the clk before its edge
  end

  //============================================================
  // Test sequence
  //============================================================

  initial begin
    clk       = 1'b0;
    rng_state = 32'd14;
    moves     = 0;
    apply_reset();

    // Reset values
    check_eq("frame_tick", frame_tick, 1'b0);
    check_eq("match_state", match_state, M_IDLE);
    check_eq("p1_x", p1_x, START_X1);
    check_eq("p2_x", p2_x, START_X2);
    check_eq("p1_state", p1_state, P_IDLE);
    check_eq("p2_state", p2_state, P_IDLE);
    check_eq("p1_health", p1_health, MAX_HEALTH);
    check_eq("p2_health", p2_health, MAX_HEALTH);
    check_eq("p1_block", p1_block, MAX_BLOCKS);
    check_eq("p2_block", p2_block, MAX_BLOCKS);
    start_round();
    check_eq("p1_x", p1_x, START_X1);
    check_eq("p2_x", p2_x, START_X2);

    // P1 walks forward into contact
    exp_x    = START_X1;
    p1_right = 1'b1;
    for (i = 0; i < 70; i++) begin
      next_frame();
      if (exp_x + STEP + BODY_W <= START_X2) exp_x = exp_x + STEP;  // Stops at contact
      check_eq("p1_x", p1_x, exp_x);
      check_eq("p1_state", p1_state, P_WALK_FWD);
    end
    p1_right = 1'b0;
    check_eq("p1_x", p1_x, START_X2 - BODY_W);

    // P2 backs off to the right wall
    exp_x    = START_X2;
    p2_right = 1'b1;
    for (i = 0; i < 45; i++) begin
      next_frame();
      exp_x = (exp_x + STEP <= ARENA_MAX) ? exp_x + STEP : ARENA_MAX;
      check_eq("p2_x", p2_x, exp_x);
      check_eq("p2_state", p2_state, P_WALK_BACK);
    end
    p2_right = 1'b0;
    close_gap();

    // Hit on idle p2 costs one health per attack plus a full hit-stun
    exp_health = MAX_HEALTH;
    exp_block  = MAX_BLOCKS;
    strike_p2(1'b0);
    for (i = 1; i <= STUN_FRAMES; i++) begin
      next_frame();
      check_eq("p2_state", p2_state, (i < STUN_FRAMES) ? P_HITSTUN : P_IDLE);
    end
    check_eq("p2_health", p2_health, exp_health);

    // Guard uses up the charges and then damage goes through
    for (i = 0; i <= MAX_BLOCKS; i++) begin
      wait_idle();
      close_gap();
      strike_p2(1'b1);
    end
    wait_idle();
    close_gap();

    // Knock p2 out
    while (exp_health > 1) begin
      strike_p2(1'b0);
      wait_idle();
    end
    strike_p2(1'b0);
    check_eq("match_state", match_state, M_FIGHT);
    next_frame();
    check_eq("match_state", match_state, M_P1_WIN);

    // Frozen after the round even once attack and stun would have run out
    frozen_p1 = p1_x;
    frozen_p2 = p2_x;
    {p1_left, p2_right} = 2'b11;
    repeat (12) next_frame();
    check_eq("p1_x", p1_x, frozen_p1);
    check_eq("p2_x", p2_x, frozen_p2);
    {p1_left, p2_right} = 2'b00;

    // New round reloads everything
    start_round();
    check_eq("p1_health", p1_health, MAX_HEALTH);
    check_eq("p2_health", p2_health, MAX_HEALTH);
    check_eq("p1_block", p1_block, MAX_BLOCKS);
    check_eq("p2_block", p2_block, MAX_BLOCKS);
    check_eq("p1_x", p1_x, START_X1);
    check_eq("p2_x", p2_x, START_X2);
    check_eq("p1_state", p1_state, P_IDLE);
    check_eq("p2_state", p2_state, P_IDLE);

    // Two CPU runs with different keys give the same p2 path
    cpu_run(0);
    cpu_run(1);
    assert (moves > 0) else fail_now("CPU never moved p2");
    for (i = 0; i < CPU_TICKS; i++) begin
      check_eq("p2_x trace", trace[1][i], trace[0][i]);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/fight_core.sv
`timescale 1ns/1ps
`default_nettype none

module fight_core
  import fight_pkg::*;
#(
  parameter int FRAME_DIV     = 4,  // Near 833333 on the board
  parameter int STEP          = 4,
  parameter int ATTACK_FRAMES = 6,
  parameter int STUN_FRAMES   = 8,
  parameter int CPU_DIV       = 3
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            start,
  input  logic            p1_left,
  input  logic            p1_right,
  input  logic            p1_attack,
  input  logic            p2_left,
  input  logic            p2_right,
  input  logic            p2_attack,
  input  logic            cpu_mode,
  output logic            frame_tick,
  output match_state_t    match_state,
  output logic [X_W-1:0]  p1_x,
  output logic [X_W-1:0]  p2_x,
  output player_state_t   p1_state,
  output player_state_t   p2_state,
  output logic [HP_W-1:0] p1_health,
  output logic [HP_W-1:0] p2_health,
  output logic [HP_W-1:0] p1_block,
  output logic [HP_W-1:0] p2_block
);

  //==========================================================
  // Internal nets
  //==========================================================

  logic round_start;
  logic p2_left_cmd;   // After the CPU mux
  logic p2_right_cmd;
  logic p2_attack_cmd;
  logic p1_struck;
  logic p2_struck;
  logic p1_stun;
  logic p2_stun;

  match_ctrl #(.FRAME_DIV(FRAME_DIV)) match_ctrl_inst (
    .clk(clk),
    .arst_n(arst_n),
    .start(start),
    .p1_health(p1_health),
    .p2_health(p2_health),
    .frame_tick(frame_tick),
    .round_start(round_start),
    .match_state(match_state)
  );

  cpu_input #(.CPU_DIV(CPU_DIV)) cpu_input_inst (
    .clk(clk),
    .arst_n(arst_n),
    .frame_tick(frame_tick),
    .cpu_mode(cpu_mode),
    .man_left(p2_left),
    .man_right(p2_right),
    .man_attack(p2_attack),
    .left(p2_left_cmd),
    .right(p2_right_cmd),
    .attack(p2_attack_cmd)
  );

  player_fsm #(
    .SIDE(1'b0),
    .STEP(STEP),
    .ATTACK_FRAMES(ATTACK_FRAMES),
    .STUN_FRAMES(STUN_FRAMES)
  ) player1_inst (
    .clk(clk),
    .arst_n(arst_n),
    .frame_tick(frame_tick),
    .round_start(round_start),
    .match_state(match_state),
    .left(p1_left),
    .right(p1_right),
    .attack(p1_attack),
    .stun(p1_stun),
    .other_x(p2_x),
    .x(p1_x),
    .state(p1_state)
  );

  player_fsm #(
    .SIDE(1'b1),
    .STEP(STEP),
    .ATTACK_FRAMES(ATTACK_FRAMES),
    .STUN_FRAMES(STUN_FRAMES)
  ) player2_inst (
    .clk(clk),
    .arst_n(arst_n),
    .frame_tick(frame_tick),
    .round_start(round_start),
    .match_state(match_state),
    .left(p2_left_cmd),
    .right(p2_right_cmd),
    .attack(p2_attack_cmd),
    .stun(p2_stun),
    .other_x(p1_x),
    .x(p2_x),
    .state(p2_state)
  );

  hit_detect hit_detect_inst (
    .clk(clk),
    .arst_n(arst_n),
    .frame_tick(frame_tick),
    .p1_x(p1_x),
    .p2_x(p2_x),
    .p1_state(p1_state),
    .p2_state(p2_state),
    .p1_struck(p1_struck),
    .p2_struck(p2_struck)
  );

  health_status health_status_inst (
    .clk(clk),
    .arst_n(arst_n),
    .round_start(round_start),
    .p1_struck(p1_struck),
    .p2_struck(p2_struck),
    .p1_state(p1_state),
    .p2_state(p2_state),
    .p1_health(p1_health),
    .p2_health(p2_health),
    .p1_block(p1_block),
    .p2_block(p2_block),
    .p1_stun(p1_stun),
    .p2_stun(p2_stun)
  );

endmodule

`default_nettype wire

// File: rtl/cpu_input.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_input #(
  parameter int CPU_DIV = 3  // Frames per new command
) (
  input  logic clk,
  input  logic arst_n,
  input  logic frame_tick,
  input  logic cpu_mode,     // 1 hands P2 to the CPU
  input  logic man_left,
  input  logic man_right,
  input  logic man_attack,
  output logic left,
  output logic right,
  output logic attack
);

  localparam logic [15:0] SEED  = 16'hace1;  // Any non-zero value
  localparam int          DIV_W = (CPU_DIV > 1) ? $clog2(CPU_DIV) : 1;

  logic [15:0]      rng;
  logic [15:0]      rng_a;
  logic [15:0]      rng_b;
  logic [15:0]      rng_next;
  logic [DIV_W-1:0] div_cnt;
  logic             step;

  // Xorshift 7/9/8, full period over the non-zero 16 bit states
  assign rng_a    = rng ^ (rng << 7);
  assign rng_b    = rng_a ^ (rng_a >> 9);
  assign rng_next = rng_b ^ (rng_b << 8);

  assign step = frame_tick && (div_cnt == DIV_W'(CPU_DIV - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rng     <= SEED;
      div_cnt <= '0;
    end else if (frame_tick) begin
      div_cnt <= step ? '0 : div_cnt + 1'b1;
      if (step) rng <= rng_next;  // Hold a command for CPU_DIV frames
    end
  end

  // Key mux, attack rarer than moves
  assign left   = cpu_mode ? rng[0] : man_left;
  assign right  = cpu_mode ? rng[1] : man_right;
  assign attack = cpu_mode ? (rng[2] & rng[3]) : man_attack;

endmodule

`default_nettype wire

// File: rtl/health_status.sv
`timescale 1ns/1ps
`default_nettype none

module health_status
  import fight_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            round_start,
  input  logic            p1_struck,
  input  logic            p2_struck,
  input  player_state_t   p1_state,
  input  player_state_t   p2_state,
  output logic [HP_W-1:0] p1_health,
  output logic [HP_W-1:0] p2_health,
  output logic [HP_W-1:0] p1_block,
  output logic [HP_W-1:0] p2_block,
  output logic            p1_stun,
  output logic            p2_stun
);

  logic [HP_W-1:0] health [2];   // Index 0 is P1
  logic [HP_W-1:0] block  [2];
  logic [1:0]      struck;
  logic [1:0]      guarding;     // Walking back holds the guard
  logic [1:0]      stun_q;

  assign struck   = {p2_struck, p1_struck};
  assign guarding = {p2_state == P_WALK_BACK, p1_state == P_WALK_BACK};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2; i++) begin
        health[i] <= MAX_HEALTH;
        block[i]  <= MAX_BLOCKS;
      end
      stun_q <= '0;
    end else begin
      stun_q <= '0;                     // Pulse, one clk
      if (round_start) begin
        for (int i = 0; i < 2; i++) begin
          health[i] <= MAX_HEALTH;
          block[i]  <= MAX_BLOCKS;
        end
      end else begin
        for (int i = 0; i < 2; i++) begin
          if (struck[i]) begin
            if (guarding[i] && (block[i] != '0)) begin
              block[i] <= block[i] - 1'b1;    // Guard absorbs the hit
            end else begin
              if (health[i] != '0) health[i] <= health[i] - 1'b1;  // Saturate at 0
              stun_q[i] <= 1'b1;
            end
          end
        end
      end
    end
  end

  assign p1_health = health[0];
  assign p2_health = health[1];
  assign p1_block  = block[0];
  assign p2_block  = block[1];
  assign p1_stun   = stun_q[0];
  assign p2_stun   = stun_q[1];

endmodule

`default_nettype wire

// File: rtl/hit_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hit_detect
  import fight_pkg::*;
(
  input  logic           clk,
  input  logic           arst_n,
  input  logic           frame_tick,
  input  logic [X_W-1:0] p1_x,
  input  logic [X_W-1:0] p2_x,
  input  player_state_t  p1_state,
  input  player_state_t  p2_state,
  output logic           p1_struck,  // P1 took a hit
  output logic           p2_struck   // P2 took a hit
);

  logic [X_W-1:0] p1_box_lo, p1_box_hi;
  logic [X_W-1:0] p2_box_lo, p2_box_hi;
  logic [X_W-1:0] p1_hurt_lo, p1_hurt_hi;
  logic [X_W-1:0] p2_hurt_lo, p2_hurt_hi;
  logic           p1_hits;      // P1 attack box on P2 body
  logic           p2_hits;
  logic           p1_landed;    // P1 already scored this attack
  logic           p2_landed;

  function automatic logic overlap(input logic [X_W-1:0] a_lo, input logic [X_W-1:0] a_hi,
                                   input logic [X_W-1:0] b_lo, input logic [X_W-1:0] b_hi);
    return (a_lo <= b_hi) && (b_lo <= a_hi);
  endfunction

  // All boxes shifted right by REACH so the left-facing box never wraps below 0
  assign p1_hurt_lo = p1_x + REACH;
  assign p1_hurt_hi = p1_x + REACH + BODY_W - 1'b1;
  assign p2_hurt_lo = p2_x + REACH;
  assign p2_hurt_hi = p2_x + REACH + BODY_W - 1'b1;
  assign p1_box_lo  = p1_x + BODY_W + REACH;          // In front of P1, facing right
  assign p1_box_hi  = p1_x + BODY_W + REACH + REACH - 1'b1;
  assign p2_box_lo  = p2_x;                           // In front of P2, facing left
  assign p2_box_hi  = p2_x + REACH - 1'b1;

  assign p1_hits = (p1_state == P_ATTACK) && !p1_landed &&
                   overlap(p1_box_lo, p1_box_hi, p2_hurt_lo, p2_hurt_hi);
  assign p2_hits = (p2_state == P_ATTACK) && !p2_landed &&
                   overlap(p2_box_lo, p2_box_hi, p1_hurt_lo, p1_hurt_hi);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p1_struck <= 1'b0;
      p2_struck <= 1'b0;
      p1_landed <= 1'b0;
      p2_landed <= 1'b0;
    end else begin
      p1_struck <= 1'b0;  // Single clk pulses
      p2_struck <= 1'b0;
      if (p1_state != P_ATTACK) p1_landed <= 1'b0;  // Rearm once the attack ends
      if (p2_state != P_ATTACK) p2_landed <= 1'b0;
      if (frame_tick) begin
        if (p1_hits) begin
          p2_struck <= 1'b1;
          p1_landed <= 1'b1;
        end
        if (p2_hits) begin  // Trades allowed on one frame
          p1_struck <= 1'b1;
          p2_landed <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: player/player_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module player_fsm
  import fight_pkg::*;
#(
  parameter bit SIDE          = 1'b0, // 0 faces right, 1 faces left
  parameter int STEP          = 4,    // Pixels per frame
  parameter int ATTACK_FRAMES = 6,
  parameter int STUN_FRAMES   = 8
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           frame_tick,
  input  logic           round_start,
  input  match_state_t   match_state,
  input  logic           left,
  input  logic           right,
  input  logic           attack,
  input  logic           stun,        // Damage pulse from health block
  input  logic [X_W-1:0] other_x,     // Opponent left edge
  output logic [X_W-1:0] x,
  output player_state_t  state
);

  localparam logic [X_W-1:0] HOME_X = SIDE ? START_X2 : START_X1;
  localparam int MAX_FR = (ATTACK_FRAMES > STUN_FRAMES) ? ATTACK_FRAMES : STUN_FRAMES;
  localparam int CNT_W  = $clog2(MAX_FR + 1);
  localparam logic [X_W-1:0] STEP_X = X_W'(STEP);

  logic [CNT_W-1:0] frame_cnt;  // Frames spent in attack or stun
  logic             fwd_key;
  logic             back_key;
  logic             fwd_ok;     // Room left before touching the opponent
  logic [X_W-1:0]   fwd_x;
  logic [X_W-1:0]   back_x;
  logic             act_tick;
  logic             attack_done;
  logic             stun_done;

  // Facing decides which key means forward
  assign fwd_key  = SIDE ? left : right;
  assign back_key = SIDE ? right : left;
  assign act_tick = frame_tick && (match_state == M_FIGHT);

  assign attack_done = (frame_cnt == CNT_W'(ATTACK_FRAMES - 1));
  assign stun_done   = (frame_cnt == CNT_W'(STUN_FRAMES - 1));

  //==========================================================
  // Candidate positions
  //==========================================================

  // Arena plus body and step stays well below 2**X_W, no overflow here
  always_comb begin
    if (!SIDE) begin
      fwd_ok = (x + BODY_W + STEP_X) <= other_x;                // Gap stays >= 0
      fwd_x  = x + STEP_X;
      back_x = (x >= ARENA_MIN + STEP_X) ? x - STEP_X : ARENA_MIN; // Clamp left wall
    end else begin
      fwd_ok = x >= (other_x + BODY_W + STEP_X);
      fwd_x  = x - STEP_X;
      back_x = (x + STEP_X <= ARENA_MAX) ? x + STEP_X : ARENA_MAX; // Clamp right wall
    end
  end

  //==========================================================
  // State machine
  //==========================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x         <= HOME_X;
      state     <= P_IDLE;
      frame_cnt <= '0;
    end else if (round_start) begin  // New round puts both fighters home
      x         <= HOME_X;
      state     <= P_IDLE;
      frame_cnt <= '0;
    end else if (stun) begin         // Hit overrides anything, even mid attack
      state     <= P_HITSTUN;
      frame_cnt <= '0;
    end else if (act_tick) begin
      case (state)
        P_ATTACK: begin
          if (attack_done) begin
            state     <= P_IDLE;
            frame_cnt <= '0;
          end else begin
            frame_cnt <= frame_cnt + 1'b1;
          end
        end
        P_HITSTUN: begin
          if (stun_done) begin
            state     <= P_IDLE;
            frame_cnt <= '0;
          end else begin
            frame_cnt <= frame_cnt + 1'b1;
          end
        end
        default: begin  // Free to act, attack wins over moves
          if (attack) begin
            state     <= P_ATTACK;
            frame_cnt <= '0;
          end else if (back_key) begin
            state <= P_WALK_BACK;
            x     <= back_x;
          end else if (fwd_key) begin
            state <= P_WALK_FWD;
            if (fwd_ok) begin
              x <= fwd_x;    // Otherwise pressed against the opponent
            end
          end else begin
            state <= P_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/match_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module match_ctrl
  import fight_pkg::*;
#(
  parameter int FRAME_DIV = 4  // Clocks per frame
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            start,
  input  logic [HP_W-1:0] p1_health,
  input  logic [HP_W-1:0] p2_health,
  output logic            frame_tick,
  output logic            round_start,
  output match_state_t    match_state
);

  localparam int CNT_W = (FRAME_DIV > 1) ? $clog2(FRAME_DIV) : 1;

  logic [CNT_W-1:0] div_cnt;
  logic             tick_next;
  logic             round_over;
  match_state_t     result;

  //==========================================================
  // Frame strobe
  //==========================================================

  assign tick_next = (div_cnt == CNT_W'(FRAME_DIV - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt    <= '0;
      frame_tick <= 1'b0;
    end else begin
      frame_tick <= tick_next;                     // First tick FRAME_DIV clks out
      div_cnt    <= tick_next ? '0 : div_cnt + 1'b1;
    end
  end

  //==========================================================
  // Round control
  //==========================================================

  always_comb begin
    round_over = (p1_health == '0) || (p2_health == '0);
    if ((p1_health == '0) && (p2_health == '0)) begin
      result = M_DRAW;
    end else if (p2_health == '0) begin
      result = M_P1_WIN;
    end else begin
      result = M_P2_WIN;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      match_state <= M_IDLE;
      round_start <= 1'b0;
    end else begin
      round_start <= 1'b0;
      if (frame_tick) begin  // Round only moves on frame boundaries
        case (match_state)
          M_FIGHT: begin
            if (round_over) match_state <= result;
          end
          default: begin     // Idle or a result screen
            if (start) begin
              round_start <= 1'b1;
              match_state <= M_FIGHT;
            end
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: common/fight_pkg.sv
`default_nettype none

package fight_pkg;

  //==========================================================
  // State encodings
  //==========================================================

  typedef enum logic [2:0] {
    P_IDLE,       // Standing still
    P_WALK_FWD,   // Moving toward the opponent
    P_WALK_BACK,  // Moving away, guard up
    P_ATTACK,     // Attack box active
    P_HITSTUN     // Recoil after taking damage
  } player_state_t;

  typedef enum logic [2:0] {
    M_IDLE,       // Waiting for start
    M_FIGHT,      // Round in progress
    M_P1_WIN,
    M_P2_WIN,
    M_DRAW        // Both knocked out on the same frame
  } match_state_t;

  //==========================================================
  // Arena geometry, all x coordinates of a left edge
  //==========================================================

  localparam int X_W = 10;                                // 640 px wide arena
  localparam logic [X_W-1:0] ARENA_MIN = 10'd0;
  localparam logic [X_W-1:0] ARENA_MAX = 10'd608;         // 640 minus body width
  localparam logic [X_W-1:0] BODY_W    = 10'd32;          // Hurtbox width
  localparam logic [X_W-1:0] REACH     = 10'd24;          // Attack depth past the body
  localparam logic [X_W-1:0] START_X1  = 10'd160;
  localparam logic [X_W-1:0] START_X2  = 10'd448;

  // Health and guard
  localparam int HP_W = 3;
  localparam logic [HP_W-1:0] MAX_HEALTH = 3'd5;
  localparam logic [HP_W-1:0] MAX_BLOCKS = 3'd3;

endpackage

`default_nettype wire
